/* src/code_lock_pkg.sv */
package code_lock_pkg;

    localparam int KEY_W       = 16;
    localparam int CODE_DIGITS = 3;
    localparam int DIGIT_W     = 4;
    localparam int LOCK_DIGITS = 2;  // seconds field during lockout
    localparam int TRIES_W     = 4;
    localparam int CFG_DATA_W  = CODE_DIGITS * DIGIT_W;

    // key word bit positions, digits sit on bits 0..9
    localparam int KEY_DIGIT_MAX = 9;
    localparam int KEY_ENTER     = 10;
    localparam int KEY_CLEAR     = 11;
    localparam int KEY_LOCK      = 12;

    localparam logic [DIGIT_W-1:0] BLANK_DIGIT = 4'hf;

    localparam logic [CODE_DIGITS-1:0][DIGIT_W-1:0] BLANK_CODE =
        {CODE_DIGITS{BLANK_DIGIT}};
    localparam logic [CODE_DIGITS-1:0][DIGIT_W-1:0] DEFAULT_PASSWORD =
        {4'd2, 4'd4, 4'd6};
    localparam logic [TRIES_W-1:0] DEFAULT_MAX_TRIES = 4'd3;

    // shortened for simulation
    localparam logic [31:0] TICK_DIV = 32'd20;
    localparam logic [LOCK_DIGITS-1:0][DIGIT_W-1:0] LOCKOUT_SECONDS = 8'h05;

    localparam int TONE_W = 8;
    localparam logic [TONE_W-1:0] CLICK_LEN   = 8'd16;
    localparam logic [TONE_W-1:0] CLICK_HALF  = 8'd2;
    localparam logic [TONE_W-1:0] OK_LEN      = 8'd60;
    localparam logic [TONE_W-1:0] OK_HALF     = 8'd1;
    localparam logic [TONE_W-1:0] FAIL_LEN    = 8'd90;
    localparam logic [TONE_W-1:0] FAIL_HALF   = 8'd4;
    localparam logic [TONE_W-1:0] FAIL_GAP_LO = 8'd30;  // silent window start
    localparam logic [TONE_W-1:0] FAIL_GAP_HI = 8'd60;

    localparam logic CFG_ADDR_PASSWORD = 1'b0;
    localparam logic CFG_ADDR_TRIES    = 1'b1;

    typedef enum logic [1:0] {
        KIND_DIGIT,
        KIND_ENTER,
        KIND_CLEAR,
        KIND_LOCK
    } key_kind_t;

    typedef struct packed {
        logic               valid;
        key_kind_t          kind;
        logic [DIGIT_W-1:0] digit;
    } key_event_t;

    typedef enum logic [1:0] {
        TONE_NONE,
        TONE_CLICK,
        TONE_OK,
        TONE_FAIL
    } tone_t;

    typedef enum logic [1:0] {
        MODE_ENTRY,
        MODE_OPEN,
        MODE_LOCKOUT
    } display_mode_t;

    typedef struct packed {
        display_mode_t                         mode;
        logic [CODE_DIGITS-1:0][DIGIT_W-1:0]   digits;  // [2] is leftmost
    } lock_display_t;

endpackage

/* src/keypad_decoder.sv */
`timescale 1ns/1ps

module keypad_decoder (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [code_lock_pkg::KEY_W-1:0] keys,
    output code_lock_pkg::key_event_t       ev
);
    import code_lock_pkg::*;

    logic [KEY_W-1:0]         keys_q;
    logic [KEY_W-1:0]         keys_prev;
    logic [$clog2(KEY_W)-1:0] key_idx;
    logic                     one_hot;
    logic                     known;
    key_kind_t                kind;

    // position of the set bit, only meaningful when one_hot
    always_comb begin
        key_idx = '0;
        for (int i = 0; i < KEY_W; i++) begin
            if (keys_q[i]) begin
                key_idx = ($clog2(KEY_W))'(i);
            end
        end
    end

    assign one_hot = (keys_q != '0) && ((keys_q & (keys_q - 1'b1)) == '0);

    always_comb begin
        kind  = KIND_DIGIT;
        known = 1'b1;
        if (key_idx == KEY_ENTER) begin
            kind = KIND_ENTER;
        end else if (key_idx == KEY_CLEAR) begin
            kind = KIND_CLEAR;
        end else if (key_idx == KEY_LOCK) begin
            kind = KIND_LOCK;
        end else if (key_idx > KEY_DIGIT_MAX) begin
            known = 1'b0;  // spare keys 13..15
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            keys_q    <= '0;
            keys_prev <= '0;
            ev        <= '0;
        end else begin
            keys_q    <= keys;
            keys_prev <= keys_q;
            ev.valid  <= 1'b0;
            if (one_hot && known && (keys_q != keys_prev)) begin
                ev <= '{valid: 1'b1, kind: kind, digit: key_idx};
            end
        end
    end

endmodule

/* src/lock_config.sv */
`timescale 1ns/1ps

module lock_config (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   cfg_we,
    input  logic                                   cfg_addr,
    input  logic [code_lock_pkg::CFG_DATA_W-1:0]   cfg_wdata,
    output logic [code_lock_pkg::CODE_DIGITS-1:0][code_lock_pkg::DIGIT_W-1:0] password,
    output logic [code_lock_pkg::TRIES_W-1:0]      max_tries
);
    import code_lock_pkg::*;

    logic [TRIES_W-1:0] tries_wr;

    // a limit of zero would lock out before any try
    assign tries_wr = (cfg_wdata[TRIES_W-1:0] == '0) ? TRIES_W'(1)
                                                     : cfg_wdata[TRIES_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            password  <= DEFAULT_PASSWORD;
            max_tries <= DEFAULT_MAX_TRIES;
        end else if (cfg_we) begin
            if (cfg_addr == CFG_ADDR_PASSWORD) begin
                password <= cfg_wdata;  // three bcd digits, msd first
            end else if (cfg_addr == CFG_ADDR_TRIES) begin
                max_tries <= tries_wr;
            end
        end
    end

endmodule

/* src/code_lock_ctrl.sv */
`timescale 1ns/1ps

module code_lock_ctrl (
    input  logic                              clk,
    input  logic                              arst_n,
    input  code_lock_pkg::key_event_t         ev,
    input  logic [code_lock_pkg::CODE_DIGITS-1:0][code_lock_pkg::DIGIT_W-1:0] password,
    input  logic [code_lock_pkg::TRIES_W-1:0] max_tries,
    input  logic [code_lock_pkg::LOCK_DIGITS-1:0][code_lock_pkg::DIGIT_W-1:0] remaining,
    input  logic                              lockout_done,
    output logic                              lockout_start,
    output logic                              tone_req,
    output code_lock_pkg::tone_t              tone_sel,
    output code_lock_pkg::lock_display_t      display,
    output logic                              unlocked,
    output logic                              locked_out
);
    import code_lock_pkg::*;

    display_mode_t                       state_q, state_d;
    logic [CODE_DIGITS-1:0][DIGIT_W-1:0] entry_q, entry_d;
    logic [1:0]                          cnt_q, cnt_d;  // digits entered so far
    logic [TRIES_W-1:0]                  tries_q, tries_d;
    logic [TRIES_W:0]                    tries_inc;
    logic                                start_d;
    logic                                req_d;
    tone_t                               sel_d;

    assign tries_inc = {1'b0, tries_q} + 1'b1;

    always_comb begin
        state_d = state_q;
        entry_d = entry_q;
        cnt_d   = cnt_q;
        tries_d = tries_q;
        start_d = 1'b0;
        req_d   = 1'b0;
        sel_d   = TONE_NONE;
        case (state_q)
            MODE_ENTRY: begin
                if (ev.valid) begin
                    case (ev.kind)
                        KIND_DIGIT: begin
                            if (cnt_q < CODE_DIGITS) begin
                                entry_d = {entry_q[CODE_DIGITS-2:0], ev.digit};  // shift left
                                cnt_d   = cnt_q + 2'd1;
                                req_d   = 1'b1;
                                sel_d   = TONE_CLICK;
                            end
                        end
                        KIND_ENTER: begin
                            if (cnt_q == CODE_DIGITS) begin
                                entry_d = BLANK_CODE;
                                cnt_d   = '0;
                                req_d   = 1'b1;
                                if (entry_q == password) begin
                                    state_d = MODE_OPEN;
                                    sel_d   = TONE_OK;
                                    tries_d = '0;
                                end else begin
                                    sel_d = TONE_FAIL;
                                    if (tries_inc >= {1'b0, max_tries}) begin
                                        state_d = MODE_LOCKOUT;
                                        start_d = 1'b1;
                                        tries_d = '0;
                                    end else begin
                                        tries_d = tries_inc[TRIES_W-1:0];
                                    end
                                end
                            end
                        end
                        default: begin  // clear and lock both blank the entry
                            entry_d = BLANK_CODE;
                            cnt_d   = '0;
                        end
                    endcase
                end
            end
            MODE_OPEN: begin
                if (ev.valid && (ev.kind == KIND_LOCK)) begin
                    state_d = MODE_ENTRY;
                end
            end
            MODE_LOCKOUT: begin
                if (lockout_done) begin
                    state_d = MODE_ENTRY;  // keys stay dropped until here
                end
            end
            default: state_d = MODE_ENTRY;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= MODE_ENTRY;
            entry_q       <= BLANK_CODE;
            cnt_q         <= '0;
            tries_q       <= '0;
            lockout_start <= 1'b0;
            tone_req      <= 1'b0;
        end else begin
            state_q       <= state_d;
            entry_q       <= entry_d;
            cnt_q         <= cnt_d;
            tries_q       <= tries_d;
            lockout_start <= start_d;
            tone_req      <= req_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_d) begin
            tone_sel <= sel_d;
        end
    end

    always_comb begin
        display.mode = state_q;
        case (state_q)
            MODE_OPEN:    display.digits = '0;
            MODE_LOCKOUT: display.digits = {{((CODE_DIGITS-LOCK_DIGITS)*DIGIT_W){1'b0}},
                                            remaining};
            default:      display.digits = entry_q;
        endcase
    end

    assign unlocked   = (state_q == MODE_OPEN);
    assign locked_out = (state_q == MODE_LOCKOUT);

endmodule

/* src/lockout_timer.sv */
`timescale 1ns/1ps

module lockout_timer (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic [code_lock_pkg::LOCK_DIGITS-1:0][code_lock_pkg::DIGIT_W-1:0] remaining,
    output logic done
);
    import code_lock_pkg::*;

    logic [31:0] pre_cnt;
    logic        running;
    logic        tick;

    assign tick = running && (pre_cnt == TICK_DIV - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running   <= 1'b0;
            pre_cnt   <= '0;
            remaining <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running   <= 1'b1;
                pre_cnt   <= 32'd1;  // start cycle counts toward the first second
                remaining <= LOCKOUT_SECONDS;
            end else if (tick) begin
                pre_cnt <= '0;
                if (remaining[0] == '0) begin
                    remaining[1] <= remaining[1] - 1'b1;  // borrow from tens
                    remaining[0] <= 4'd9;
                end else begin
                    remaining[0] <= remaining[0] - 1'b1;
                end
                if (remaining == 8'h01) begin
                    running <= 1'b0;
                    done    <= 1'b1;  // last second gone
                end
            end else if (running) begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

endmodule

/* src/tone_gen.sv */
`timescale 1ns/1ps

module tone_gen (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 tone_req,
    input  code_lock_pkg::tone_t tone_sel,
    output logic                 buzzer
);
    import code_lock_pkg::*;

    tone_t             sel_q;
    logic              active;
    logic              wave;
    logic              in_gap;
    logic [TONE_W-1:0] dur_cnt;
    logic [TONE_W-1:0] half_cnt;
    logic [TONE_W-1:0] len;
    logic [TONE_W-1:0] half;

    // pattern table
    always_comb begin
        case (sel_q)
            TONE_CLICK: begin
                len  = CLICK_LEN;
                half = CLICK_HALF;
            end
            TONE_OK: begin
                len  = OK_LEN;
                half = OK_HALF;
            end
            TONE_FAIL: begin
                len  = FAIL_LEN;
                half = FAIL_HALF;
            end
            default: begin
                len  = '1;
                half = '1;
            end
        endcase
    end

    assign in_gap = (sel_q == TONE_FAIL) && (dur_cnt >= FAIL_GAP_LO) && (dur_cnt < FAIL_GAP_HI);
    assign buzzer = active && wave && !in_gap;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            wave   <= 1'b0;
        end else if (tone_req) begin
            active <= (tone_sel != TONE_NONE);  // restart on every request
            wave   <= (tone_sel != TONE_NONE);
        end else if (active) begin
            if (dur_cnt == len - 1'b1) begin
                active <= 1'b0;
                wave   <= 1'b0;
            end else if (half_cnt == half - 1'b1) begin
                wave <= ~wave;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tone_req) begin
            sel_q    <= tone_sel;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            dur_cnt  <= dur_cnt + 1'b1;
            half_cnt <= (half_cnt == half - 1'b1) ? '0 : half_cnt + 1'b1;
        end
    end

endmodule

/* src/code_lock_top.sv */
`timescale 1ns/1ps

module code_lock_top (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [code_lock_pkg::KEY_W-1:0]      keys,
    input  logic                                 cfg_we,
    input  logic                                 cfg_addr,
    input  logic [code_lock_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output code_lock_pkg::lock_display_t         display,
    output logic                                 unlocked,
    output logic                                 locked_out,
    output logic                                 buzzer
);
    import code_lock_pkg::*;

    key_event_t                          ev;
    logic [CODE_DIGITS-1:0][DIGIT_W-1:0] password;
    logic [TRIES_W-1:0]                  max_tries;
    logic [LOCK_DIGITS-1:0][DIGIT_W-1:0] remaining;
    logic                                lockout_start;
    logic                                lockout_done;
    logic                                tone_req;
    tone_t                               tone_sel;

    keypad_decoder keypad_decoder_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .keys   (keys),
        .ev     (ev)
    );

    lock_config lock_config_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .password  (password),
        .max_tries (max_tries)
    );

    code_lock_ctrl code_lock_ctrl_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .ev            (ev),
        .password      (password),
        .max_tries     (max_tries),
        .remaining     (remaining),
        .lockout_done  (lockout_done),
        .lockout_start (lockout_start),
        .tone_req      (tone_req),
        .tone_sel      (tone_sel),
        .display       (display),
        .unlocked      (unlocked),
        .locked_out    (locked_out)
    );

    lockout_timer lockout_timer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (lockout_start),
        .remaining (remaining),
        .done      (lockout_done)
    );

    tone_gen tone_gen_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .tone_req (tone_req),
        .tone_sel (tone_sel),
        .buzzer   (buzzer)
    );

endmodule

/* sim/code_lock_checker.sv */
`timescale 1ns/1ps

module code_lock_checker (
    input logic                      clk,
    input logic                      arst_n,
    input code_lock_pkg::key_event_t ev,
    input logic                      lockout_start,
    input logic                      lockout_done,
    input logic                      tone_req,
    input logic                      unlocked,
    input logic                      locked_out,
    input logic                      buzzer
);
    import code_lock_pkg::*;

    localparam int LOCKOUT_CYCLES = 100;  // 5 seconds of 20 cycles

    int         fail_count = 0;
    logic [7:0] quiet_cnt;  // cycles since the last tone request

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            quiet_cnt <= '1;
        end else if (tone_req) begin
            quiet_cnt <= '0;
        end else if (quiet_cnt != '1) begin
            quiet_cnt <= quiet_cnt + 1'b1;
        end
    end

    not_open_and_locked: assert property (@(posedge clk) disable iff (!arst_n)
        !(unlocked && locked_out))
        else begin
            fail_count++;
            $error("unlocked and locked_out are high together");
        end

    silent_without_tone: assert property (@(posedge clk) disable iff (!arst_n)
        (quiet_cnt > FAIL_LEN) |-> !buzzer)
        else begin
            fail_count++;
            $error("buzzer high with no tone running");
        end

    single_cycle_event: assert property (@(posedge clk) disable iff (!arst_n)
        ev.valid |=> !ev.valid)
        else begin
            fail_count++;
            $error("key event valid for two cycles in a row");
        end

    lockout_length: assert property (@(posedge clk) disable iff (!arst_n)
        lockout_start |-> ##LOCKOUT_CYCLES lockout_done)
        else begin
            fail_count++;
            $error("lockout done not seen %0d cycles after start", LOCKOUT_CYCLES);
        end

endmodule

bind code_lock_top code_lock_checker code_lock_checker_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .ev            (ev),
    .lockout_start (lockout_start),
    .lockout_done  (lockout_done),
    .tone_req      (tone_req),
    .unlocked      (unlocked),
    .locked_out    (locked_out),
    .buzzer        (buzzer)
);

/* sim/code_lock_tb.sv */
`timescale 1ns/1ps

module code_lock_tb;
    import code_lock_pkg::*;

    localparam int LOCKOUT_CYCLES = 100;  // 5 seconds of 20 cycles
    localparam int MAX_CYCLES     = 4000;

    logic          clk = 1'b0;
    logic          arst_n;
    logic [15:0]   keys;
    logic          cfg_we;
    logic          cfg_addr;
    logic [11:0]   cfg_wdata;
    lock_display_t display;
    logic          unlocked;
    logic          locked_out;
    logic          buzzer;

    integer seed     = 87;
    int     cycles   = 0;
    int     errors   = 0;
    int     err_mark = 0;
    int     passed   = 0;
    int     failed   = 0;
    int     lo_run   = 0;  // edges seen with locked_out high
    int     toggles  = 0;
    logic   buz_prev = 1'b0;

    display_mode_t   m_state;  // reference model
    logic [2:0][3:0] m_entry;
    logic [2:0][3:0] m_pw;
    int              m_cnt;
    int              m_tries;
    int              m_max;

    code_lock_top code_lock_top_inst (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (locked_out) begin
            lo_run++;
        end else begin
            lo_run = 0;
        end
        if (buzzer !== buz_prev) begin
            toggles++;
        end
        buz_prev = buzzer;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic int total_errors();
        return errors + code_lock_top_inst.code_lock_checker_inst.fail_count;
    endfunction

    task automatic model_key(input int idx);
        if (m_state == MODE_ENTRY) begin
            if (idx <= 9) begin
                if (m_cnt < 3) begin
                    m_entry = {m_entry[1:0], 4'(idx)};
                    m_cnt++;
                end
            end else if (idx == KEY_ENTER) begin
                if (m_cnt == 3) begin
                    if (m_entry == m_pw) begin
                        m_state = MODE_OPEN;
                        m_tries = 0;
                    end else begin
                        m_tries++;
                        if (m_tries >= m_max) begin
                            m_state = MODE_LOCKOUT;
                            m_tries = 0;
                        end
                    end
                    m_entry = 12'hfff;
                    m_cnt   = 0;
                end
            end else begin  // clear or lock
                m_entry = 12'hfff;
                m_cnt   = 0;
            end
        end else if (m_state == MODE_OPEN && idx == KEY_LOCK) begin
            m_state = MODE_ENTRY;
            m_entry = 12'hfff;
            m_cnt   = 0;
        end
    endtask

    task automatic check(input string name);
        lock_display_t exp;
        exp.mode   = m_state;
        exp.digits = (m_state == MODE_ENTRY) ? m_entry : 12'h000;
        if (m_state == MODE_LOCKOUT) begin
            // seconds run down while keys are pressed, only 1..5 is valid
            assert (display.mode == MODE_LOCKOUT && display.digits >= 12'h001
                    && display.digits <= 12'h005 && locked_out && !unlocked)
            else begin
                $display("Error %s: expected lockout with 1..5 s, actual mode %0d digits %h",
                         name, display.mode, display.digits);
                errors++;
            end
        end else begin
            assert ({display, unlocked, locked_out} ==
                    {exp, m_state == MODE_OPEN, 1'b0})
            else begin
                $display("Error %s: expected %h actual %h", name,
                         {exp, m_state == MODE_OPEN, 1'b0}, {display, unlocked, locked_out});
                errors++;
            end
        end
    endtask

    task automatic press_word(input logic [15:0] word, input int idx, input string name);
        keys = word;
        repeat (3) @(posedge clk);
        #1 keys = '0;
        repeat (3) @(posedge clk);
        #1;
        if (idx >= 0) begin
            model_key(idx);
        end
        check(name);
    endtask

    task automatic press(input int idx, input string name);
        press_word(16'd1 << idx, idx, name);
    endtask

    task automatic enter_code(input logic [2:0][3:0] code, input string name);
        for (int i = 2; i >= 0; i--) begin
            press(int'(code[i]), name);
        end
        press(KEY_ENTER, name);
    endtask

    task automatic random_wrong(output logic [2:0][3:0] code);
        do begin
            for (int i = 0; i < 3; i++) begin
                code[i] = 4'($unsigned($random(seed)) % 10);
            end
        end while (code == m_pw);
    endtask

    task automatic write_cfg(input logic addr, input logic [11:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1 cfg_we = 1'b0;
        if (addr == 1'b0) begin
            m_pw = data;
        end else begin
            m_max = (data[3:0] == 4'd0) ? 1 : int'(data[3:0]);
        end
    endtask

    task automatic wait_lockout(input string name);
        int waited;
        waited = 0;
        while (locked_out && waited < 2 * LOCKOUT_CYCLES) begin
            @(posedge clk);
            #1 waited++;
        end
        assert (!locked_out && lo_run == LOCKOUT_CYCLES + 1)
        else begin
            $display("Error %s: expected lockout of %0d cycles, actual %0d",
                     name, LOCKOUT_CYCLES + 1, lo_run);
            errors++;
        end
        m_state = MODE_ENTRY;  // lockout done returns to entry
        check(name);
    endtask

    task automatic end_test(input string name);
        if (total_errors() == err_mark) begin
            $display("test %s passed", name);
            passed++;
        end else begin
            $display("test %s failed with %0d errors", name, total_errors() - err_mark);
            failed++;
        end
        err_mark = total_errors();
    endtask

    initial begin
        logic [2:0][3:0] code;
        arst_n    = 1'b0;
        keys      = '0;
        cfg_we    = 1'b0;
        cfg_addr  = 1'b0;
        cfg_wdata = '0;
        m_state   = MODE_ENTRY;
        m_entry   = 12'hfff;
        m_pw      = 12'h246;
        m_cnt     = 0;
        m_tries   = 0;
        m_max     = 3;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;

        check("open");
        enter_code(12'h246, "open");
        press(KEY_LOCK, "open");
        end_test("open");

        repeat (3) begin
            random_wrong(code);
            enter_code(code, "lockout");
        end
        press(1, "lockout");  // dropped while locked out
        press(9, "lockout");
        wait_lockout("lockout");
        random_wrong(code);
        enter_code(code, "lockout");
        enter_code(12'h246, "lockout");
        press(KEY_LOCK, "lockout");
        end_test("lockout");

        write_cfg(CFG_ADDR_PASSWORD, 12'h701);
        write_cfg(CFG_ADDR_TRIES, 12'h002);
        enter_code(12'h246, "config");
        random_wrong(code);
        enter_code(code, "config");
        wait_lockout("config");
        enter_code(12'h701, "config");
        press(KEY_LOCK, "config");
        end_test("config");

        press(5, "entry");
        press(3, "entry");
        press(KEY_CLEAR, "entry");
        for (int d = 1; d <= 4; d++) begin
            press(d, "entry");  // fourth digit ignored
        end
        press(KEY_CLEAR, "entry");
        press(8, "entry");
        press(KEY_ENTER, "entry");
        press(KEY_CLEAR, "entry");
        random_wrong(code);
        enter_code(code, "entry");  // first counted try only
        press_word(16'h0030, -1, "entry");
        end_test("entry");

        press(KEY_CLEAR, "tone");
        repeat (100) @(posedge clk);
        #1;
        assert (buzzer == 1'b0)
        else begin
            $display("Error tone: expected buzzer 0 actual %b", buzzer);
            errors++;
        end
        toggles = 0;
        press(3, "tone");
        repeat (CLICK_LEN) @(posedge clk);
        #1;
        assert (toggles > 0)
        else begin
            $display("tone: buzzer never toggled after a digit press");
            errors++;
        end
        assert (buzzer == 1'b0)
        else begin
            $display("Error tone: expected buzzer 0 actual %b", buzzer);
            errors++;
        end
        end_test("tone");

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, total_errors());
        if (total_errors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
src/code_lock_pkg.sv
src/keypad_decoder.sv
src/lock_config.sv
src/code_lock_ctrl.sv
src/lockout_timer.sv
src/tone_gen.sv
src/code_lock_top.sv
sim/code_lock_checker.sv
sim/code_lock_tb.sv
